// File: Makefile
SIM = obj_dir/Vtb_pattern_fetch

$(SIM): pattern_fetch_top.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert --top-module tb_pattern_fetch \
		-f pattern_fetch_top.f -o Vtb_pattern_fetch

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: fetch_ifs.sv
`timescale 1ns/10ps

// command channel, sequencer to memory reader
interface seq_if
    import pattern_fetch_pkg::*;
();
    logic      cmd_req;
    seq_cmd_t  cmd;
    logic      cmd_ack;
    logic      hdr_valid;
    pat_cnt_t  pat_total;
    line_cnt_t pat_lines;

    modport master (
        output cmd_req, cmd,
        input  cmd_ack, hdr_valid, pat_total, pat_lines
    );

    modport slave (
        input  cmd_req, cmd,
        output cmd_ack, hdr_valid, pat_total, pat_lines
    );
endinterface

// block refill channel, serializer to memory reader
interface block_if
    import pattern_fetch_pkg::*;
();
    logic   req;
    logic   ack;
    block_t block;

    modport requester (output req, input ack, block);
    modport supplier (input req, output ack, block);
endinterface

// File: frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer
    import pattern_fetch_pkg::*;
(
    input  logic   clk,
    input  logic   ddr3_emif_rst_n,
    input  logic   v_sync_in,
    input  logic   de_in,
    input  logic   frame_busy,
    output logic   frame_trig,
    output logic   streaming,
    output logic   frame_start,
    seq_if.master  seq
);

    seq_state_t state;
    pat_cnt_t   pat_cnt;
    line_cnt_t  line_cnt;
    logic       staged;
    logic       trig_wait;
    logic       v_sync_d;
    logic       de_d;
    logic       v_rise;
    logic       de_rise;
    logic       de_fall;
    logic       cmd_idle;
    logic       cmd_done;
    logic       frame_end;

    assign v_rise  = v_sync_in & ~v_sync_d;
    assign de_rise = de_in & ~de_d;
    assign de_fall = ~de_in & de_d;

    // four-phase command handshake phases
    assign cmd_idle = !seq.cmd_req && !seq.cmd_ack;
    assign cmd_done = seq.cmd_req && seq.cmd_ack;

    // trigger only when the display side is free
    assign frame_trig  = !frame_busy &&
                         ((state == LOAD && staged) || (state == SEND && trig_wait));
    assign frame_start = frame_trig && (state == LOAD);
    assign streaming   = (state == SEND) && !trig_wait;
    assign frame_end   = streaming && de_fall && (line_cnt == seq.pat_lines);

    // ------------------------------------------------------------------------
    // sync edges and line count
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            v_sync_d <= 1'b0;
            de_d     <= 1'b0;
            line_cnt <= '0;
        end else begin
            v_sync_d <= v_sync_in;
            de_d     <= de_in;
            if (v_rise) begin
                line_cnt <= '0;
            end else if (de_rise) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // pattern FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            state       <= IDLE;
            seq.cmd_req <= 1'b0;
            seq.cmd     <= READ_HDR;
            pat_cnt     <= '0;
            staged      <= 1'b0;
            trig_wait   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // poll the header until the magic byte shows up
                    if (cmd_idle) begin
                        seq.cmd_req <= 1'b1;
                        seq.cmd     <= READ_HDR;
                    end else if (cmd_done) begin
                        seq.cmd_req <= 1'b0;
                        if (seq.hdr_valid) begin
                            pat_cnt <= '0;
                            state   <= LOAD;
                        end
                    end
                end
                LOAD: begin
                    if (cmd_idle && !staged) begin
                        seq.cmd_req <= 1'b1;
                        seq.cmd     <= STREAM;
                    end else if (cmd_done) begin
                        seq.cmd_req <= 1'b0;
                        staged      <= 1'b1;
                    end else if (frame_trig) begin
                        staged <= 1'b0;
                        state  <= SEND;
                    end
                end
                SEND: begin
                    if (frame_trig) begin
                        trig_wait <= 1'b0;
                    end else if (frame_end) begin
                        pat_cnt <= pat_cnt + 1'b1;
                        if (pat_cnt == seq.pat_total - 1'b1) begin
                            state <= DONE;
                        end else begin
                            trig_wait <= 1'b1;
                        end
                    end
                end
                default: begin
                    // clear the header, then resume polling
                    if (cmd_idle) begin
                        seq.cmd_req <= 1'b1;
                        seq.cmd     <= CLEAR_HDR;
                    end else if (cmd_done) begin
                        seq.cmd_req <= 1'b0;
                        state       <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: mem_reader.sv
`timescale 1ns/10ps
`include "pattern_fetch_cfg.svh"

module mem_reader
    import pattern_fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 ddr3_emif_rst_n,
    output logic                 onchip_mem_chip_select,
    output logic                 onchip_mem_clk_ena,
    output logic                 onchip_mem_chip_read,
    output logic                 onchip_mem_write,
    output mem_addr_t            onchip_mem_addr,
    output logic [`MEM_BE_W-1:0] onchip_mem_byte_enable,
    output mem_word_t            onchip_mem_write_data,
    input  mem_word_t            onchip_mem_read_data,
    seq_if.slave                 seq,
    block_if.supplier            blk
);

    localparam int WCNT_W = $clog2(`WORDS_PER_BLOCK + 1);

    rd_state_t             rd_state;
    mem_addr_t             rd_ptr;
    logic [`MEM_RD_LAT-1:0] rd_vld;
    logic [WCNT_W-1:0]     issue_cnt;
    logic [WCNT_W-1:0]     wcnt;
    logic                  fill_cmd;
    logic                  data_vld;

    // the header clear is the only write, always zero data
    assign onchip_mem_write_data = '0;

    // read data sits on the bus MEM_RD_LAT cycles after chip_read
    assign data_vld = rd_vld[`MEM_RD_LAT-1];

    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            rd_vld <= '0;
        end else begin
            rd_vld <= {rd_vld[`MEM_RD_LAT-2:0], onchip_mem_chip_read};
        end
    end

    // staging block, word 0 lands in the top bits
    always_ff @(posedge clk) begin
        if (rd_state == RD_FILL && data_vld) begin
            blk.block[`BLOCK_W-1 - int'(wcnt)*`MEM_W -: `MEM_W] <= onchip_mem_read_data;
        end
    end

    // ------------------------------------------------------------------------
    // command and refill engine
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            rd_state               <= RD_IDLE;
            rd_ptr                 <= mem_addr_t'(`DATA_BASE_ADDR);
            issue_cnt              <= '0;
            wcnt                   <= '0;
            fill_cmd               <= 1'b0;
            seq.cmd_ack            <= 1'b0;
            seq.hdr_valid          <= 1'b0;
            seq.pat_total          <= '0;
            seq.pat_lines          <= '0;
            blk.ack                <= 1'b0;
            onchip_mem_chip_select <= 1'b0;
            onchip_mem_clk_ena     <= 1'b0;
            onchip_mem_chip_read   <= 1'b0;
            onchip_mem_write       <= 1'b0;
            onchip_mem_addr        <= '0;
            onchip_mem_byte_enable <= '0;
        end else begin
            onchip_mem_clk_ena     <= 1'b1;
            onchip_mem_chip_select <= 1'b0;
            onchip_mem_chip_read   <= 1'b0;
            onchip_mem_write       <= 1'b0;
            onchip_mem_byte_enable <= '0;
            case (rd_state)
                RD_IDLE: begin
                    // release phases of both handshakes
                    if (seq.cmd_ack && !seq.cmd_req) begin
                        seq.cmd_ack <= 1'b0;
                    end
                    if (blk.ack && !blk.req) begin
                        blk.ack <= 1'b0;
                    end
                    // a pending refill goes ahead of any command
                    if (blk.req && !blk.ack) begin
                        fill_cmd  <= 1'b0;
                        issue_cnt <= '0;
                        wcnt      <= '0;
                        rd_state  <= RD_FILL;
                    end else if (seq.cmd_req && !seq.cmd_ack) begin
                        case (seq.cmd)
                            READ_HDR: begin
                                onchip_mem_chip_select <= 1'b1;
                                onchip_mem_chip_read   <= 1'b1;
                                onchip_mem_addr        <= mem_addr_t'(`HDR_ADDR);
                                rd_state               <= RD_HDR;
                            end
                            STREAM: begin
                                rd_ptr    <= mem_addr_t'(`DATA_BASE_ADDR);
                                fill_cmd  <= 1'b1;
                                issue_cnt <= '0;
                                wcnt      <= '0;
                                rd_state  <= RD_FILL;
                            end
                            default: begin
                                onchip_mem_chip_select <= 1'b1;
                                onchip_mem_write       <= 1'b1;
                                onchip_mem_addr        <= mem_addr_t'(`HDR_ADDR);
                                onchip_mem_byte_enable <= '1;
                                rd_state               <= RD_WRITE;
                            end
                        endcase
                    end
                end
                RD_HDR: begin
                    if (data_vld) begin
                        seq.hdr_valid <= (onchip_mem_read_data[7:0] == `HDR_MAGIC);
                        seq.pat_total <= onchip_mem_read_data[`HDR_TOTAL_LSB +: `PAT_CNT_W];
                        seq.pat_lines <= onchip_mem_read_data[`HDR_LINES_LSB +: `LINE_CNT_W];
                        seq.cmd_ack   <= 1'b1;
                        rd_state      <= RD_IDLE;
                    end
                end
                RD_FILL: begin
                    // back to back reads from the pointer
                    if (issue_cnt != WCNT_W'(`WORDS_PER_BLOCK)) begin
                        onchip_mem_chip_select <= 1'b1;
                        onchip_mem_chip_read   <= 1'b1;
                        onchip_mem_addr        <= rd_ptr;
                        rd_ptr                 <= rd_ptr + 1'b1;
                        issue_cnt              <= issue_cnt + 1'b1;
                    end
                    if (data_vld) begin
                        wcnt <= wcnt + 1'b1;
                        if (wcnt == WCNT_W'(`WORDS_PER_BLOCK - 1)) begin
                            if (fill_cmd) begin
                                seq.cmd_ack <= 1'b1;
                            end else begin
                                blk.ack <= 1'b1;
                            end
                            rd_state <= RD_IDLE;
                        end
                    end
                end
                default: begin
                    // write cycle is over
                    seq.cmd_ack <= 1'b1;
                    rd_state    <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

// File: pattern_fetch_cfg.svh
`ifndef PATTERN_FETCH_CFG_SVH
`define PATTERN_FETCH_CFG_SVH

// pixel and memory geometry
`define PIX_W            24
`define MEM_W            256
`define MEM_AW           13
`define MEM_BE_W         32
`define WORDS_PER_BLOCK  3
`define BLOCK_W          768
`define PIX_PER_BLOCK    32
`define PIX_PER_LINE     80
`define MEM_RD_LAT       2

// header word layout
`define HDR_MAGIC        8'h55
`define HDR_ADDR         0
`define DATA_BASE_ADDR   1
`define HDR_TOTAL_LSB    32
`define HDR_LINES_LSB    128
`define PAT_CNT_W        32
`define LINE_CNT_W       12

`endif

// File: pattern_fetch_pkg.sv
`include "pattern_fetch_cfg.svh"

package pattern_fetch_pkg;

    typedef logic [`PIX_W-1:0]                  pix_t;
    typedef logic [`MEM_W-1:0]                  mem_word_t;
    typedef logic [`MEM_AW-1:0]                 mem_addr_t;
    typedef logic [`BLOCK_W-1:0]                block_t;
    typedef logic [$clog2(`PIX_PER_BLOCK)-1:0]  pix_idx_t;
    typedef logic [`LINE_CNT_W-1:0]             line_cnt_t;
    typedef logic [`PAT_CNT_W-1:0]              pat_cnt_t;

    // commands from the sequencer to the memory reader
    typedef enum logic [1:0] {
        READ_HDR,
        STREAM,
        CLEAR_HDR
    } seq_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SEND,
        DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_HDR,
        RD_FILL,
        RD_WRITE
    } rd_state_t;

endpackage

// File: pattern_fetch_sva.sv
`timescale 1ns/10ps
`include "pattern_fetch_cfg.svh"

module pattern_fetch_sva
    import pattern_fetch_pkg::*;
(
    input logic                 clk,
    input logic                 ddr3_emif_rst_n,
    input logic                 frame_trig,
    input logic                 frame_busy,
    input logic                 onchip_mem_chip_select,
    input logic                 onchip_mem_chip_read,
    input logic                 onchip_mem_write,
    input mem_addr_t            onchip_mem_addr,
    input logic [`MEM_BE_W-1:0] onchip_mem_byte_enable
);

    // trigger is a single-cycle pulse
    trig_pulse: assert property (@(posedge clk) disable iff (!ddr3_emif_rst_n)
        frame_trig |=> !frame_trig)
        else $error("frame_trig high for more than one cycle");

    trig_busy: assert property (@(posedge clk) disable iff (!ddr3_emif_rst_n)
        frame_trig |-> !frame_busy)
        else $error("frame_trig while frame_busy high");

    // memory port
    read_sel: assert property (@(posedge clk) disable iff (!ddr3_emif_rst_n)
        onchip_mem_chip_read |-> onchip_mem_chip_select && !onchip_mem_write)
        else $error("read without chip select or together with a write");

    write_hdr: assert property (@(posedge clk) disable iff (!ddr3_emif_rst_n)
        onchip_mem_write |-> onchip_mem_chip_select && onchip_mem_addr == '0 &&
                             (&onchip_mem_byte_enable))
        else $error("write is not a full header clear");

endmodule

bind pattern_fetch_top pattern_fetch_sva u_sva (
    .clk                    (clk),
    .ddr3_emif_rst_n        (ddr3_emif_rst_n),
    .frame_trig             (frame_trig),
    .frame_busy             (frame_busy),
    .onchip_mem_chip_select (onchip_mem_chip_select),
    .onchip_mem_chip_read   (onchip_mem_chip_read),
    .onchip_mem_write       (onchip_mem_write),
    .onchip_mem_addr        (onchip_mem_addr),
    .onchip_mem_byte_enable (onchip_mem_byte_enable)
);

// File: pattern_fetch_top.f
+incdir+.
pattern_fetch_pkg.sv
fetch_ifs.sv
mem_reader.sv
frame_sequencer.sv
pixel_serializer.sv
pattern_fetch_top.sv
pattern_fetch_sva.sv
tb_pattern_fetch.sv

// File: pattern_fetch_top.sv
`timescale 1ns/10ps
`include "pattern_fetch_cfg.svh"

module pattern_fetch_top
    import pattern_fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 ddr3_emif_rst_n,
    output logic                 onchip_mem_chip_select,
    output logic                 onchip_mem_clk_ena,
    output logic                 onchip_mem_chip_read,
    output logic                 onchip_mem_write,
    output mem_addr_t            onchip_mem_addr,
    output logic [`MEM_BE_W-1:0] onchip_mem_byte_enable,
    output mem_word_t            onchip_mem_write_data,
    input  mem_word_t            onchip_mem_read_data,
    input  logic                 frame_busy,
    output logic                 frame_trig,
    input  logic                 h_sync_in,
    input  logic                 v_sync_in,
    input  logic                 de_in,
    output logic                 h_sync_out,
    output logic                 v_sync_out,
    output logic                 de_out,
    output pix_t                 pix_data_out
);

    logic streaming;
    logic frame_start;

    seq_if   u_seq_if ();
    block_if u_blk_if ();

    mem_reader u_mem_reader (
        .clk                    (clk),
        .ddr3_emif_rst_n        (ddr3_emif_rst_n),
        .onchip_mem_chip_select (onchip_mem_chip_select),
        .onchip_mem_clk_ena     (onchip_mem_clk_ena),
        .onchip_mem_chip_read   (onchip_mem_chip_read),
        .onchip_mem_write       (onchip_mem_write),
        .onchip_mem_addr        (onchip_mem_addr),
        .onchip_mem_byte_enable (onchip_mem_byte_enable),
        .onchip_mem_write_data  (onchip_mem_write_data),
        .onchip_mem_read_data   (onchip_mem_read_data),
        .seq                    (u_seq_if.slave),
        .blk                    (u_blk_if.supplier)
    );

    frame_sequencer u_frame_sequencer (
        .clk             (clk),
        .ddr3_emif_rst_n (ddr3_emif_rst_n),
        .v_sync_in       (v_sync_in),
        .de_in           (de_in),
        .frame_busy      (frame_busy),
        .frame_trig      (frame_trig),
        .streaming       (streaming),
        .frame_start     (frame_start),
        .seq             (u_seq_if.master)
    );

    pixel_serializer u_pixel_serializer (
        .clk             (clk),
        .ddr3_emif_rst_n (ddr3_emif_rst_n),
        .h_sync_in       (h_sync_in),
        .v_sync_in       (v_sync_in),
        .de_in           (de_in),
        .streaming       (streaming),
        .frame_start     (frame_start),
        .h_sync_out      (h_sync_out),
        .v_sync_out      (v_sync_out),
        .de_out          (de_out),
        .pix_data_out    (pix_data_out),
        .blk             (u_blk_if.requester)
    );

endmodule

// File: pixel_serializer.sv
`timescale 1ns/10ps
`include "pattern_fetch_cfg.svh"

module pixel_serializer
    import pattern_fetch_pkg::*;
(
    input  logic       clk,
    input  logic       ddr3_emif_rst_n,
    input  logic       h_sync_in,
    input  logic       v_sync_in,
    input  logic       de_in,
    input  logic       streaming,
    input  logic       frame_start,
    output logic       h_sync_out,
    output logic       v_sync_out,
    output logic       de_out,
    output pix_t       pix_data_out,
    block_if.requester blk
);

    localparam int LPIX_W = $clog2(`PIX_PER_LINE + 1);

    block_t            cur_block;
    pix_idx_t          pix_idx;
    logic [LPIX_W-1:0] line_pix;
    logic              emit;
    logic              swap;

    // only the first PIX_PER_LINE cycles of a line carry pattern data
    assign emit = streaming && de_in && (line_pix < LPIX_W'(`PIX_PER_LINE));
    assign swap = emit && (pix_idx == pix_idx_t'(`PIX_PER_BLOCK - 1));

    always_ff @(posedge clk) begin
        if (frame_start || swap) begin
            cur_block <= blk.block;
        end
    end

    always_ff @(posedge clk or negedge ddr3_emif_rst_n) begin
        if (!ddr3_emif_rst_n) begin
            h_sync_out   <= 1'b0;
            v_sync_out   <= 1'b0;
            de_out       <= 1'b0;
            pix_data_out <= '0;
            pix_idx      <= '0;
            line_pix     <= '0;
            blk.req      <= 1'b0;
        end else begin
            // timing passes through with one cycle of delay
            h_sync_out <= h_sync_in;
            v_sync_out <= v_sync_in;
            de_out     <= de_in;

            if (!de_in) begin
                line_pix <= '0;
            end else if (line_pix != LPIX_W'(`PIX_PER_LINE)) begin
                line_pix <= line_pix + 1'b1;
            end

            if (emit) begin
                pix_data_out <= cur_block[`BLOCK_W-1 - int'(pix_idx)*`PIX_W -: `PIX_W];
            end else begin
                pix_data_out <= '0;
            end

            if (frame_start) begin
                pix_idx <= '0;
            end else if (emit) begin
                pix_idx <= pix_idx + 1'b1;
            end

            // ask for the next block as soon as the staged one is taken
            if (frame_start || swap) begin
                blk.req <= 1'b1;
            end else if (blk.ack) begin
                blk.req <= 1'b0;
            end
        end
    end

endmodule

// File: tb_pattern_fetch.sv
`timescale 1ns/10ps
`include "pattern_fetch_cfg.svh"

module tb_pattern_fetch;
    import pattern_fetch_pkg::*;

    localparam int LINE_DE      = 84;
    localparam int LINE_BLANK   = 16;
    localparam int MAX_LINES    = 4;
    localparam int MAX_PATS     = 3;
    localparam int NUM_HDRS     = 3;
    localparam int DATA_WORDS   = 128;
    localparam int IDLE_CYC     = 1000;
    localparam int FRAME_CYC    = 8 + MAX_LINES * (LINE_DE + LINE_BLANK);
    localparam int WATCHDOG_CYC = 2 * IDLE_CYC + NUM_HDRS * (4 * MAX_PATS * FRAME_CYC + IDLE_CYC);

    logic                 clk;
    logic                 ddr3_emif_rst_n;
    logic                 onchip_mem_chip_select;
    logic                 onchip_mem_clk_ena;
    logic                 onchip_mem_chip_read;
    logic                 onchip_mem_write;
    mem_addr_t            onchip_mem_addr;
    logic [`MEM_BE_W-1:0] onchip_mem_byte_enable;
    mem_word_t            onchip_mem_write_data;
    mem_word_t            onchip_mem_read_data = '0;
    logic                 frame_busy = 1'b0;
    logic                 frame_trig;
    logic                 h_sync_in;
    logic                 v_sync_in;
    logic                 de_in;
    logic                 h_sync_out;
    logic                 v_sync_out;
    logic                 de_out;
    pix_t                 pix_data_out;

    // memory model and its load port
    mem_word_t mem [256];
    mem_word_t image [256];
    mem_word_t rd_stage = '0;
    logic      load_en;
    logic [7:0] load_addr;
    mem_word_t load_data;

    // monitor state
    int   trig_cnt = 0;
    int   wr_cnt = 0;
    int   rd_cnt = 0;
    int   pix_seen = 0;
    int   pix_base = 0;
    int   col = 0;
    logic h_prev = 1'b0;
    logic v_prev = 1'b0;
    logic de_prev = 1'b0;

    pattern_fetch_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYC * 20);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic report_error(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // ------------------------------------------------------------------------
    // on-chip memory, two cycles of read latency
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (onchip_mem_chip_select && onchip_mem_write) begin
            for (int b = 0; b < `MEM_BE_W; b++) begin
                if (onchip_mem_byte_enable[b]) begin
                    mem[onchip_mem_addr[7:0]][b*8 +: 8] <= onchip_mem_write_data[b*8 +: 8];
                end
            end
        end else if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (onchip_mem_chip_select && onchip_mem_chip_read) begin
            rd_stage <= mem[onchip_mem_addr[7:0]];
        end
        onchip_mem_read_data <= rd_stage;
    end

    // display side busy, toggles at random
    always @(posedge clk) begin
        if ($urandom % 8 == 0) begin
            frame_busy <= !frame_busy;
        end
    end

    // pixel k of the stream, word 0 of each block in the top bits
    function automatic pix_t expected_pixel(input int k);
        int     blk_n;
        int     p;
        block_t b;
        blk_n = k / `PIX_PER_BLOCK;
        p     = k % `PIX_PER_BLOCK;
        b     = {image[1 + 3*blk_n], image[2 + 3*blk_n], image[3 + 3*blk_n]};
        return b[`BLOCK_W-1 - p*`PIX_W -: `PIX_W];
    endfunction

    // ------------------------------------------------------------------------
    // output monitor, sampled on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (ddr3_emif_rst_n) begin
            assert (!(frame_trig && frame_busy))
                else report_error("frame_trig pulsed while frame_busy was high");
            assert (!onchip_mem_chip_select || onchip_mem_clk_ena)
                else report_error("memory accessed while the clock enable was low");
            assert (h_sync_out == h_prev && v_sync_out == v_prev && de_out == de_prev)
                else report_error("timing outputs differ from inputs one cycle earlier");
            if (frame_trig) begin
                trig_cnt++;
            end
            if (onchip_mem_chip_select && onchip_mem_chip_read) begin
                rd_cnt++;
            end
            if (onchip_mem_chip_select && onchip_mem_write) begin
                assert (onchip_mem_addr == '0 && onchip_mem_write_data == '0 &&
                        onchip_mem_byte_enable == '1)
                    else report_error($sformatf("bad write at address %0d", onchip_mem_addr));
                wr_cnt++;
            end
            if (de_out && col < `PIX_PER_LINE) begin
                assert (pix_data_out == expected_pixel(pix_seen - pix_base))
                    else report_error($sformatf("pixel %0d is %h, expected %h",
                        pix_seen - pix_base, pix_data_out, expected_pixel(pix_seen - pix_base)));
                pix_seen++;
            end else begin
                assert (pix_data_out == '0)
                    else report_error($sformatf("pixel %h outside the active area", pix_data_out));
            end
            col = de_out ? col + 1 : 0;
        end
        h_prev  = h_sync_in;
        v_prev  = v_sync_in;
        de_prev = de_in;
    end

    task automatic load_word(input int addr, input mem_word_t data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_addr <= addr[7:0];
        load_data <= data;
        image[addr] = data;
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    function automatic mem_word_t random_word();
        mem_word_t w;
        for (int i = 0; i < 8; i++) begin
            w[i*32 +: 32] = $urandom;
        end
        return w;
    endfunction

    // v_sync pulse, short blank, then the active lines
    task automatic send_frame(input int lines);
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            v_sync_in <= (c < 4);
        end
        for (int l = 0; l < lines; l++) begin
            for (int c = 0; c < LINE_DE + LINE_BLANK; c++) begin
                @(posedge clk);
                de_in     <= (c < LINE_DE);
                h_sync_in <= (c >= LINE_DE + 4) && (c < LINE_DE + 12);
            end
        end
    endtask

    task automatic run_sequence();
        int        total;
        int        lines;
        int        trig0;
        int        wr0;
        int        rd0;
        mem_word_t hdr;
        total = 1 + $urandom % MAX_PATS;
        lines = 2 + $urandom % (MAX_LINES - 1);
        for (int a = 1; a <= DATA_WORDS; a++) begin
            load_word(a, random_word());
        end
        trig0    = trig_cnt;
        wr0      = wr_cnt;
        pix_base = pix_seen;
        hdr      = random_word();
        hdr[7:0] = `HDR_MAGIC;
        hdr[`HDR_TOTAL_LSB +: `PAT_CNT_W]  = total;
        hdr[`HDR_LINES_LSB +: `LINE_CNT_W] = lines[`LINE_CNT_W-1:0];
        load_word(0, hdr);
        for (int f = 0; f < total; f++) begin
            while (trig_cnt < trig0 + f + 1) begin
                @(posedge clk);
            end
            send_frame(lines);
        end
        while (wr_cnt == wr0) begin
            @(posedge clk);
        end
        rd0 = rd_cnt;
        repeat (IDLE_CYC / 4) @(posedge clk);
        assert (trig_cnt - trig0 == total)
            else report_error($sformatf("%0d triggers, expected %0d", trig_cnt - trig0, total));
        assert (wr_cnt - wr0 == 1)
            else report_error($sformatf("%0d header writes, expected 1", wr_cnt - wr0));
        assert (mem[0][7:0] == 8'h00)
            else report_error("header magic byte was not cleared");
        assert (rd_cnt > rd0)
            else report_error("header polling did not resume after the clear");
        assert (pix_seen - pix_base == total * lines * `PIX_PER_LINE)
            else report_error($sformatf("%0d pixels seen", pix_seen - pix_base));
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        mem_word_t bad_hdr;
        void'($urandom(10764));
        ddr3_emif_rst_n = 1'b0;
        h_sync_in       = 1'b0;
        v_sync_in       = 1'b0;
        de_in           = 1'b0;
        load_en         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        repeat (5) @(negedge clk);
        assert (!frame_trig && !onchip_mem_chip_read && !onchip_mem_chip_select &&
                !onchip_mem_write && onchip_mem_byte_enable == '0 && pix_data_out == '0)
            else report_error("outputs not at their reset values");
        @(posedge clk);
        ddr3_emif_rst_n <= 1'b1;

        // a header without the magic byte is ignored
        bad_hdr      = random_word();
        bad_hdr[7:0] = 8'hAA;
        load_word(0, bad_hdr);
        repeat (IDLE_CYC) @(posedge clk);
        assert (trig_cnt == 0 && wr_cnt == 0)
            else report_error("activity seen with an invalid header");

        for (int h = 0; h < NUM_HDRS; h++) begin
            run_sequence();
        end
        $display("TEST OK");
        $finish;
    end

endmodule
